// File: common/nx_cfg.svh
`ifndef NX_CFG_SVH
`define NX_CFG_SVH

// Ingress and egress FIFO depths in messages
`define NX_IN_DEPTH  4
`define NX_OUT_DEPTH 4

// Every message on both links is one word of this width
`define NX_MSG_W     32

// Register store geometry
`define NX_ADDR_W    6
`define NX_REG_COUNT 64
`define NX_DATA_W    24

// Command field width, top bits of each message
`define NX_CMD_W     2

// Tag padding that fills out the READ view
`define NX_TAG_W     24

`endif

// File: common/nx_pkg.sv
`default_nettype none

`include "nx_cfg.svh"

package nx_pkg;

    // Command carried in the top bits of every message
    typedef enum logic [`NX_CMD_W-1:0] {
        NX_CMD_LOAD    = 2'd0,
        NX_CMD_READ    = 2'd1,
        NX_CMD_FORWARD = 2'd2,
        NX_CMD_UNUSED  = 2'd3
    } nx_command_t;

    // LOAD view, also the layout of a read reply
    typedef struct packed {
        nx_command_t                 command;
        logic [`NX_ADDR_W-1:0]       address;
        logic [`NX_DATA_W-1:0]       data;
    } nx_load_t;

    // READ view
    // The tag only pads the word, it is not echoed back
    typedef struct packed {
        nx_command_t                 command;
        logic [`NX_ADDR_W-1:0]       address;
        logic [`NX_TAG_W-1:0]        tag;
    } nx_read_t;

    // One message word, decoded by its command field
    typedef union packed {
        logic [`NX_MSG_W-1:0]        raw;
        nx_load_t                    load;
        nx_read_t                    read;
    } nx_message_t;

endpackage

`default_nettype wire

// File: design/nx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module nx_fifo #(
      parameter int DEPTH = 4   // Number of entries
    , parameter int WIDTH = 32  // Bits per entry
) (
      input  wire              clk_i
    , input  wire              rst_i
    // Write side
    , input  wire  [WIDTH-1:0] wr_data_i
    , input  wire              wr_push_i
    // Read side, head is always presented
    , output logic [WIDTH-1:0] rd_data_o
    , input  wire              rd_pop_i
    // Status
    , output logic             empty_o
    , output logic             full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LVL_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] level;
    logic             do_push;
    logic             do_pop;

    // Step a pointer, wrapping at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o   = (level == '0);
    assign full_o    = (level == LVL_W'(DEPTH));
    // First-word fall-through, head read straight from storage
    assign rd_data_o = mem[rd_ptr];

    // Pops on empty are dropped
    assign do_pop  = rd_pop_i && !empty_o;
    // A pop frees a slot for a push in the same cycle
    assign do_push = wr_push_i && (!full_o || do_pop);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Level only moves when exactly one side acts
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Storage, written at the push edge
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/nx_inbound.sv
`timescale 1ns/1ps
`default_nettype none

module nx_inbound import nx_pkg::*; (
      input  wire         clk_i
    , input  wire         rst_i
    // Inbound four-phase link
    , input  wire         in_req_i
    , input  nx_message_t in_data_i
    , output logic        in_ack_o
    // Ingress FIFO write side
    , input  wire         fifo_full_i
    , output logic        push_o
    , output nx_message_t push_data_o
);

    // High between accepting a word and seeing req fall
    logic ack_q;

    // New request with room in the FIFO
    // Ack low means this handshake has not pushed yet, so one push per word
    assign push_o = in_req_i && !ack_q && !fifo_full_i;

    // Sender holds data stable while req is high
    assign push_data_o = in_data_i;

    assign in_ack_o = ack_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else if (push_o) begin
            // Phase 2, ack rises with the push
            ack_q <= 1'b1;
        end else if (!in_req_i) begin
            // Phase 4, release once req has dropped
            ack_q <= 1'b0;
        end
    end

    // While full, ack stays low and the sender keeps req up

endmodule

`default_nettype wire

// File: design/nx_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "nx_cfg.svh"

module nx_node import nx_pkg::*; (
      input  wire         clk_i
    , input  wire         rst_i
    // Inbound link
    , input  wire         in_req_i
    , input  nx_message_t in_data_i
    , output logic        in_ack_o
    // Outbound link
    , output logic        out_req_o
    , output nx_message_t out_data_o
    , input  wire         out_ack_i
);

    // Ingress path
    logic                  in_push;
    nx_message_t           in_push_data;
    logic                  in_full;
    logic                  in_empty;
    logic                  in_pop;
    nx_message_t           in_head;

    // Egress path
    logic                  out_push;
    nx_message_t           out_push_data;
    logic                  out_full;
    logic                  out_empty;
    logic                  out_pop;
    nx_message_t           out_head;

    // Store
    logic                  reg_wr_en;
    logic [`NX_ADDR_W-1:0] reg_wr_addr;
    logic [`NX_DATA_W-1:0] reg_wr_data;
    logic [`NX_ADDR_W-1:0] reg_rd_addr;
    logic [`NX_DATA_W-1:0] reg_rd_data;

    nx_inbound u_inbound (
          .clk_i       (clk_i)
        , .rst_i       (rst_i)
        , .in_req_i    (in_req_i)
        , .in_data_i   (in_data_i)
        , .in_ack_o    (in_ack_o)
        , .fifo_full_i (in_full)
        , .push_o      (in_push)
        , .push_data_o (in_push_data)
    );

    nx_fifo #(
          .DEPTH (`NX_IN_DEPTH)
        , .WIDTH (`NX_MSG_W)
    ) u_in_fifo (
          .clk_i     (clk_i)
        , .rst_i     (rst_i)
        , .wr_data_i (in_push_data)
        , .wr_push_i (in_push)
        , .rd_data_o (in_head)
        , .rd_pop_i  (in_pop)
        , .empty_o   (in_empty)
        , .full_o    (in_full)
    );

    nx_node_ctrl u_ctrl (
          .clk_i         (clk_i)
        , .rst_i         (rst_i)
        , .head_i        (in_head)
        , .in_empty_i    (in_empty)
        , .in_pop_o      (in_pop)
        , .out_full_i    (out_full)
        , .out_push_o    (out_push)
        , .out_data_o    (out_push_data)
        , .reg_wr_en_o   (reg_wr_en)
        , .reg_wr_addr_o (reg_wr_addr)
        , .reg_wr_data_o (reg_wr_data)
        , .reg_rd_addr_o (reg_rd_addr)
        , .reg_rd_data_i (reg_rd_data)
    );

    nx_regfile u_regfile (
          .clk_i     (clk_i)
        , .rst_i     (rst_i)
        , .wr_en_i   (reg_wr_en)
        , .wr_addr_i (reg_wr_addr)
        , .wr_data_i (reg_wr_data)
        , .rd_addr_i (reg_rd_addr)
        , .rd_data_o (reg_rd_data)
    );

    nx_fifo #(
          .DEPTH (`NX_OUT_DEPTH)
        , .WIDTH (`NX_MSG_W)
    ) u_out_fifo (
          .clk_i     (clk_i)
        , .rst_i     (rst_i)
        , .wr_data_i (out_push_data)
        , .wr_push_i (out_push)
        , .rd_data_o (out_head)
        , .rd_pop_i  (out_pop)
        , .empty_o   (out_empty)
        , .full_o    (out_full)
    );

    nx_outbound u_outbound (
          .clk_i        (clk_i)
        , .rst_i        (rst_i)
        , .fifo_empty_i (out_empty)
        , .fifo_data_i  (out_head)
        , .pop_o        (out_pop)
        , .out_req_o    (out_req_o)
        , .out_data_o   (out_data_o)
        , .out_ack_i    (out_ack_i)
    );

endmodule

`default_nettype wire

// File: design/nx_node_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "nx_cfg.svh"

module nx_node_ctrl import nx_pkg::*; (
      input  wire                   clk_i
    , input  wire                   rst_i
    // Ingress FIFO head
    , input  nx_message_t           head_i
    , input  wire                   in_empty_i
    , output logic                  in_pop_o
    // Egress FIFO write side
    , input  wire                   out_full_i
    , output logic                  out_push_o
    , output nx_message_t           out_data_o
    // Register store
    , output logic                  reg_wr_en_o
    , output logic [`NX_ADDR_W-1:0] reg_wr_addr_o
    , output logic [`NX_DATA_W-1:0] reg_wr_data_o
    , output logic [`NX_ADDR_W-1:0] reg_rd_addr_o
    , input  wire  [`NX_DATA_W-1:0] reg_rd_data_i
);

    // Purely combinational
    // All state lives in the FIFOs and the store

    logic head_valid;

    assign head_valid = !in_empty_i;

    // Address and data fields go to the store unconditionally
    assign reg_wr_addr_o = head_i.load.address;
    assign reg_wr_data_o = head_i.load.data;
    assign reg_rd_addr_o = head_i.read.address;

    always_comb begin
        in_pop_o    = 1'b0;
        out_push_o  = 1'b0;
        reg_wr_en_o = 1'b0;
        // Forwards leave bit for bit
        out_data_o  = head_i;

        case (head_i.load.command)
            NX_CMD_LOAD: begin
                // Store write never waits on the egress side
                reg_wr_en_o = head_valid;
                in_pop_o    = head_valid;
            end
            NX_CMD_READ: begin
                // Reply is a LOAD carrying the stored value
                // Read address already sits in the reply's address bits
                out_data_o.load.command = NX_CMD_LOAD;
                out_data_o.load.data    = reg_rd_data_i;
                // Head stays put until egress has room
                out_push_o = head_valid && !out_full_i;
                in_pop_o   = head_valid && !out_full_i;
            end
            NX_CMD_FORWARD: begin
                out_push_o = head_valid && !out_full_i;
                in_pop_o   = head_valid && !out_full_i;
            end
            default: begin
                // Unused command is dropped
                in_pop_o = head_valid;
            end
        endcase
    end

    // Ordering holds since only the head is ever acted on

endmodule

`default_nettype wire

// File: design/nx_outbound.sv
`timescale 1ns/1ps
`default_nettype none

module nx_outbound import nx_pkg::*; (
      input  wire         clk_i
    , input  wire         rst_i
    // Egress FIFO read side
    , input  wire         fifo_empty_i
    , input  nx_message_t fifo_data_i
    , output logic        pop_o
    // Outbound four-phase link
    , output logic        out_req_o
    , output nx_message_t out_data_o
    , input  wire         out_ack_i
);

    // Link state is held by req and the returning ack
    //   idle    : req low,  ack low
    //   request : req high, waiting for ack
    //   release : req low,  waiting for ack to fall
    logic        req_q;
    logic        start;
    nx_message_t data_q;

    // Only begin a word from idle with something queued
    assign start = !fifo_empty_i && !req_q && !out_ack_i;

    // Word is captured here, so the FIFO can advance right away
    assign pop_o = start;

    assign out_req_o  = req_q;
    assign out_data_o = data_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            req_q <= 1'b0;
        end else if (start) begin
            // Phase 1
            req_q <= 1'b1;
        end else if (req_q && out_ack_i) begin
            // Phase 3, drop req on the first ack
            req_q <= 1'b0;
        end
    end

    // Held for the whole handshake
    always_ff @(posedge clk_i) begin
        if (start) begin
            data_q <= fifo_data_i;
        end
    end

    // Release ends when the receiver drops ack, start then sees idle again

endmodule

`default_nettype wire

// File: design/nx_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "nx_cfg.svh"

module nx_regfile (
      input  wire                   clk_i
    , input  wire                   rst_i
    // Write port
    , input  wire                   wr_en_i
    , input  wire  [`NX_ADDR_W-1:0] wr_addr_i
    , input  wire  [`NX_DATA_W-1:0] wr_data_i
    // Read port, combinational
    , input  wire  [`NX_ADDR_W-1:0] rd_addr_i
    , output logic [`NX_DATA_W-1:0] rd_data_o
);

    logic [`NX_DATA_W-1:0] regs [`NX_REG_COUNT];

    // Unwritten registers read back as zero
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NX_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Write lands at the edge, a read in the next cycle sees it
    assign rd_data_o = regs[rd_addr_i];

endmodule

`default_nettype wire

// File: dv/nx_node_properties.sv
`timescale 1ns/1ps
`default_nettype none

module nx_node_properties import nx_pkg::*; (
      input  wire         clk_i
    , input  wire         rst_i
    // Link signals, seen from inside the node
    , input  wire         in_req_i
    , input  wire         in_ack_i
    , input  wire         out_req_i
    , input  nx_message_t out_data_i
    , input  wire         out_ack_i
    // FIFO controls
    , input  wire         in_push_i
    , input  wire         in_full_i
    , input  wire         in_pop_i
    , input  wire         out_push_i
    , input  wire         out_full_i
    , input  wire         out_pop_i
);

    // Outbound req holds, and its word stays frozen, until ack arrives
    out_req_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
        out_req_i && !out_ack_i |=> out_req_i && $stable(out_data_i.raw))
        else $error("outbound req dropped or data moved before ack");

    // Inbound ack only falls after req has gone
    in_ack_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
        in_ack_i && in_req_i |=> in_ack_i)
        else $error("inbound ack fell while req still high");

    // No push into a full FIFO unless a pop frees the slot
    in_fifo_safe_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(in_push_i && in_full_i && !in_pop_i))
        else $error("ingress FIFO pushed while full");

    out_fifo_safe_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(out_push_i && out_full_i && !out_pop_i))
        else $error("egress FIFO pushed while full");

    // Both links quiet while reset is held
    reset_quiet_a: assert property (@(posedge clk_i)
        rst_i |-> !in_ack_i && !out_req_i)
        else $error("link handshake active during reset");

endmodule

bind nx_node nx_node_properties u_properties (
      .clk_i      (clk_i)
    , .rst_i      (rst_i)
    , .in_req_i   (in_req_i)
    , .in_ack_i   (in_ack_o)
    , .out_req_i  (out_req_o)
    , .out_data_i (out_data_o)
    , .out_ack_i  (out_ack_i)
    , .in_push_i  (in_push)
    , .in_full_i  (in_full)
    , .in_pop_i   (in_pop)
    , .out_push_i (out_push)
    , .out_full_i (out_full)
    , .out_pop_i  (out_pop)
);

`default_nettype wire

// File: dv/nx_node_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nx_cfg.svh"

module nx_node_tb import nx_pkg::*; ();

    localparam int CYCLE_LIMIT  = 4000;
    // Quiet cycles on ack that count as a stalled ingress
    localparam int STALL_CYCLES = 20;
    localparam int MAX_BURST    = 16;

    logic        clk_i;
    logic        rst_i;
    logic        in_req_i;
    nx_message_t in_data_i;
    logic        in_ack_o;
    logic        out_req_o;
    nx_message_t out_data_o;
    logic        out_ack_i;

    int          seed;
    int          cycle_count = 0;

    // Reference model state
    logic [`NX_DATA_W-1:0] shadow [`NX_REG_COUNT];
    nx_message_t           stim_q[$];
    nx_message_t           expect_q[$];

    nx_node u_nx_node (
          .clk_i      (clk_i)
        , .rst_i      (rst_i)
        , .in_req_i   (in_req_i)
        , .in_data_i  (in_data_i)
        , .in_ack_o   (in_ack_o)
        , .out_req_o  (out_req_o)
        , .out_data_o (out_data_o)
        , .out_ack_i  (out_ack_i)
    );

    always #4 clk_i = ~clk_i;

    // Run limit of roughly four times the longest test
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_message(input string name, input nx_message_t exp,
                                 input nx_message_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Everything is driven and sampled 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Model of one accepted message
    task automatic model_apply(input nx_message_t msg);
        nx_message_t reply;
        case (msg.load.command)
            NX_CMD_LOAD: begin
                shadow[msg.load.address] = msg.load.data;
            end
            NX_CMD_READ: begin
                // Reply uses the LOAD layout and drops the tag
                reply.load.command = NX_CMD_LOAD;
                reply.load.address = msg.read.address;
                reply.load.data    = shadow[msg.read.address];
                expect_q.push_back(reply);
            end
            NX_CMD_FORWARD: begin
                expect_q.push_back(msg);
            end
            default: begin
                // Command 3 leaves no trace
            end
        endcase
    endtask

    task automatic enqueue_stimulus(input nx_message_t msg);
        stim_q.push_back(msg);
        model_apply(msg);
    endtask

    // Phases 2 to 4 of an inbound handshake already under way
    task automatic finish_send();
        while (in_ack_o !== 1'b1) begin
            step_cycle();
        end
        in_req_i = 1'b0;
        while (in_ack_o !== 1'b0) begin
            step_cycle();
        end
    endtask

    task automatic send_word(input nx_message_t msg);
        in_data_i = msg;
        in_req_i  = 1'b1;
        finish_send();
    endtask

    // One outbound handshake checked against the model queue
    task automatic expect_word();
        nx_message_t exp;
        while (out_req_o !== 1'b1) begin
            step_cycle();
        end
        if (expect_q.size() == 0) begin
            $display("Outbound word %h appeared with no reply pending", out_data_o.raw);
            abort_run();
        end
        exp = expect_q.pop_front();
        check_message("out_data_o", exp, out_data_o);
        out_ack_i = 1'b1;
        while (out_req_o !== 1'b0) begin
            step_cycle();
        end
        out_ack_i = 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            step_cycle();
            check_bit("out_req_o", 1'b0, out_req_o);
        end
    endtask

    // Sender and receiver run side by side over the queued stimulus
    task automatic run_stream();
        int n;
        n = expect_q.size();
        fork
            begin
                foreach (stim_q[i]) begin
                    send_word(stim_q[i]);
                end
            end
            begin
                repeat (n) begin
                    expect_word();
                end
            end
        join
        stim_q.delete();
        check_idle(12);
    endtask

    task automatic test_reset();
        check_bit("in_ack_o", 1'b0, in_ack_o);
        check_bit("out_req_o", 1'b0, out_req_o);
        check_idle(10);
    endtask

    task automatic test_forward_order();
        nx_message_t msg;
        repeat (8) begin
            msg.raw          = $random(seed);
            msg.load.command = NX_CMD_FORWARD;
            enqueue_stimulus(msg);
        end
        run_stream();
    endtask

    task automatic test_load_read();
        nx_message_t msg;
        // Never written and so read back as zero
        msg.read.command = NX_CMD_READ;
        msg.read.address = 6'h3f;
        msg.read.tag     = 24'($random(seed));
        enqueue_stimulus(msg);
        repeat (8) begin
            msg.load.command = NX_CMD_LOAD;
            msg.load.address = 6'($random(seed));
            msg.load.data    = 24'($random(seed));
            enqueue_stimulus(msg);
            // Same address with the tag over the data bits
            msg.read.command = NX_CMD_READ;
            msg.read.tag     = 24'($random(seed));
            enqueue_stimulus(msg);
        end
        run_stream();
    endtask

    task automatic test_dropped_command();
        nx_message_t msg;
        msg.raw          = $random(seed);
        msg.load.command = NX_CMD_UNUSED;
        enqueue_stimulus(msg);
        msg.raw          = $random(seed);
        msg.load.command = NX_CMD_FORWARD;
        enqueue_stimulus(msg);
        run_stream();
    endtask

    task automatic test_back_pressure();
        nx_message_t msg;
        int          accepted;
        int          wait_cycles;
        int          n;
        logic        stalled;
        accepted = 0;
        stalled  = 1'b0;
        // Outbound ack stays low so both FIFOs fill
        while (!stalled && accepted < MAX_BURST) begin
            msg.raw          = $random(seed);
            msg.load.command = NX_CMD_FORWARD;
            in_data_i        = msg;
            in_req_i         = 1'b1;
            wait_cycles      = 0;
            while (in_ack_o !== 1'b1 && wait_cycles < STALL_CYCLES) begin
                step_cycle();
                wait_cycles++;
            end
            // The stalled word still gets through later
            model_apply(msg);
            if (in_ack_o === 1'b1) begin
                finish_send();
                accepted++;
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled) begin
            $display("Ingress never stalled after %0d words", accepted);
            abort_run();
        end
        if (accepted < `NX_IN_DEPTH + `NX_OUT_DEPTH) begin
            $display("Only %0d words accepted before ingress stalled", accepted);
            abort_run();
        end
        n = expect_q.size();
        fork
            finish_send();
            begin
                repeat (n) begin
                    expect_word();
                end
            end
        join
        check_idle(12);
    endtask

    task automatic test_mixed_stream();
        nx_message_t msg;
        repeat (60) begin
            msg.raw = $random(seed);
            // Narrow address range so reads hit earlier loads
            msg.load.address[5:3] = 3'b000;
            enqueue_stimulus(msg);
        end
        run_stream();
    endtask

    initial begin
        seed        = 32'h16ad_b898;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        in_req_i    = 1'b0;
        in_data_i   = '0;
        out_ack_i   = 1'b0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (3) begin
            @(posedge clk_i);
        end
        #1;
        rst_i = 1'b0;

        test_reset();
        test_forward_order();
        test_load_read();
        test_dropped_command();
        test_back_pressure();
        test_mixed_stream();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: nx_node.f
+incdir+common
common/nx_pkg.sv
design/nx_fifo.sv
design/nx_inbound.sv
design/nx_outbound.sv
design/nx_regfile.sv
design/nx_node_ctrl.sv
design/nx_node.sv
dv/nx_node_properties.sv
dv/nx_node_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the node testbench with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f nx_node.f --top-module nx_node_tb \
        --Mdir obj_dir -o nx_node_sim \
    && ./obj_dir/nx_node_sim 2>&1 | tee sim.log \
    && grep -q "^No errors$" sim.log \
    || { echo "Simulation did not pass"; exit 1; }

echo "Simulation passed"
